//--- logic/motor_pkg.sv
package motor_pkg;

  // Channel count, one axis_channel each
  localparam int NUM_AXES = 2;

  // Step period in CLK cycles
  localparam int PERIOD_BITS = 16;

  // 256 microsteps per electrical cycle
  localparam int PHASE_BITS = 8;

  // Resolution code r advances the phase by 2**(PHASE_BITS-1-r) per step
  localparam int USTEP_CODE_BITS = 3;

  localparam int POSITION_BITS = 32;  // Signed microstep position
  localparam int ENC_BITS = 16;  // Signed encoder count

  // Reset hold time, 2**4 cycles
  localparam int RESET_STRETCH_BITS = 4;

endpackage

//--- logic/spi_pkg.sv
package spi_pkg;

  // Frame is write flag, then address, then data, MSB first
  localparam int FRAME_BITS = 24;
  localparam int ADDR_BITS = 7;
  localparam int DATA_BITS = 16;

  // Wide enough to count a full frame plus overrun
  localparam int BIT_COUNT_BITS = $clog2(FRAME_BITS + 1);

  // Upper address bits select the axis, low bits the register
  localparam int AXIS_SHIFT = 3;

  // Per-axis register map
  localparam logic [AXIS_SHIFT-1:0] REG_CONFIG = 3'd0;  // Bit 0 enable, bits 3:1 resolution
  localparam logic [AXIS_SHIFT-1:0] REG_PERIOD = 3'd1;  // CLK cycles per step
  localparam logic [AXIS_SHIFT-1:0] REG_MOVE = 3'd2;  // Signed step count, launches
  localparam logic [AXIS_SHIFT-1:0] REG_POSITION = 3'd3;  // Read-only
  localparam logic [AXIS_SHIFT-1:0] REG_ENCODER = 3'd4;  // Read-only
  localparam logic [AXIS_SHIFT-1:0] REG_STATUS = 3'd5;  // Busy and sticky fault

endpackage

//--- logic/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch (
  input  logic CLK,
  input  logic resetn_in,
  output logic resetn
);
  import motor_pkg::*;

  logic [RESET_STRETCH_BITS-1:0] hold_count;

  // Count up to all ones, release one cycle later
  always_ff @(posedge CLK) begin
    if (!resetn_in) begin
      hold_count <= '0;
      resetn <= 1'b0;
    end else begin
      if (!(&hold_count)) begin
        hold_count <= hold_count + 1'b1;
      end
      resetn <= &hold_count;
    end
  end

endmodule

//--- logic/spi_register_port.sv
`timescale 1ns/1ps

module spi_register_port (
  input  logic CLK,
  input  logic resetn,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  output logic cipo,
  output logic wr_strobe,
  output logic [spi_pkg::ADDR_BITS-1:0] wr_addr,
  output logic [spi_pkg::DATA_BITS-1:0] wr_data,
  output logic rd_strobe,
  output logic [spi_pkg::ADDR_BITS-1:0] rd_addr,
  input  logic [spi_pkg::DATA_BITS-1:0] rd_data
);
  import spi_pkg::*;

  // Index 1 is the synchronized level, index 2 the one before
  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [1:0] copi_sync;

  logic sck_rise;
  logic sck_fall;
  logic cs_rise;
  logic cs_fall;
  logic frame_done;

  logic [FRAME_BITS-1:0] shift_in;
  logic [BIT_COUNT_BITS-1:0] bit_count;
  logic [FRAME_BITS-1:0] shift_out;
  logic [ADDR_BITS-1:0] frame_addr;
  logic load_pending;  // rd_data valid next cycle

  always_ff @(posedge CLK) begin
    sck_sync <= {sck_sync[1:0], sck};
    cs_sync <= {cs_sync[1:0], cs};
    copi_sync <= {copi_sync[0], copi};
  end

  assign sck_rise = sck_sync[1] && !sck_sync[2];
  assign sck_fall = !sck_sync[1] && sck_sync[2];
  assign cs_rise = cs_sync[1] && !cs_sync[2];
  assign cs_fall = !cs_sync[1] && cs_sync[2];

  // Only a frame of exactly FRAME_BITS bits is decoded
  assign frame_done = cs_rise && (bit_count == BIT_COUNT_BITS'(FRAME_BITS));

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_count <= '0;
    end else if (cs_fall) begin
      bit_count <= '0;
    end else if (sck_rise && !cs_sync[1] && !(&bit_count)) begin
      bit_count <= bit_count + 1'b1;  // Saturates on long frames
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_sync[1]) begin
      shift_in <= {shift_in[FRAME_BITS-2:0], copi_sync[1]};
    end
  end

  // Write flag picks the strobe
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_strobe <= 1'b0;
      rd_strobe <= 1'b0;
    end else begin
      wr_strobe <= frame_done && shift_in[FRAME_BITS-1];
      rd_strobe <= frame_done && !shift_in[FRAME_BITS-1];
    end
  end

  always_ff @(posedge CLK) begin
    if (frame_done) begin
      frame_addr <= shift_in[FRAME_BITS-2 -: ADDR_BITS];
      wr_data <= shift_in[DATA_BITS-1:0];
    end
  end

  assign wr_addr = frame_addr;
  assign rd_addr = frame_addr;

  // Readback goes out in the low bits of the next frame
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      load_pending <= 1'b0;
      shift_out <= '0;
    end else begin
      load_pending <= rd_strobe;
      if (load_pending) begin
        shift_out <= {{(FRAME_BITS - DATA_BITS){1'b0}}, rd_data};
      end else if (sck_fall && !cs_sync[1]) begin
        shift_out <= {shift_out[FRAME_BITS-2:0], 1'b0};  // Mode 0, change on falling
      end
    end
  end

  assign cipo = !cs && shift_out[FRAME_BITS-1];

endmodule

//--- logic/quad_encoder.sv
`timescale 1ns/1ps

module quad_encoder (
  input  logic CLK,
  input  logic resetn,
  input  logic enc_a,
  input  logic enc_b,
  output logic signed [motor_pkg::ENC_BITS-1:0] count,
  output logic fault_pulse
);

  // Index 1 is the current state, index 2 the previous one
  logic [2:0] a_sync;
  logic [2:0] b_sync;
  logic a_moved;
  logic b_moved;

  always_ff @(posedge CLK) begin
    a_sync <= {a_sync[1:0], enc_a};
    b_sync <= {b_sync[1:0], enc_b};
  end

  assign a_moved = a_sync[1] ^ a_sync[2];
  assign b_moved = b_sync[1] ^ b_sync[2];

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      count <= '0;
      fault_pulse <= 1'b0;
    end else begin
      // Both lines at once is not a legal Gray step
      fault_pulse <= a_moved && b_moved;
      if (a_moved != b_moved) begin
        // b leading means new a follows old b
        if (a_sync[1] == b_sync[2]) begin
          count <= count + 1'b1;
        end else begin
          count <= count - 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/axis_channel.sv
`timescale 1ns/1ps

module axis_channel #(
  parameter int AXIS_INDEX = 0
) (
  input  logic CLK,
  input  logic resetn,
  input  logic wr_strobe,
  input  logic [spi_pkg::ADDR_BITS-1:0] wr_addr,
  input  logic [spi_pkg::DATA_BITS-1:0] wr_data,
  input  logic enc_a,
  input  logic enc_b,
  output logic step_out,
  output logic dir_out,  // High for a negative move
  output logic busy,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic signed [motor_pkg::POSITION_BITS-1:0] position,
  output logic signed [motor_pkg::ENC_BITS-1:0] enc_count,
  output logic enc_fault_pulse
);
  import motor_pkg::*;
  import spi_pkg::*;

  logic axis_hit;
  logic [AXIS_SHIFT-1:0] reg_sel;
  logic cfg_write;
  logic period_write;
  logic move_write;

  logic enable;
  logic [USTEP_CODE_BITS-1:0] ustep_code;
  logic [PERIOD_BITS-1:0] period;
  logic [PERIOD_BITS-1:0] period_count;
  logic [DATA_BITS-1:0] remaining;
  logic [DATA_BITS-1:0] move_mag;
  logic [PHASE_BITS-1:0] phase_index;
  logic [PHASE_BITS-1:0] phase_inc;
  logic [1:0] quadrant;
  logic step_due;

  assign axis_hit = wr_addr[ADDR_BITS-1:AXIS_SHIFT] == (ADDR_BITS - AXIS_SHIFT)'(AXIS_INDEX);
  assign reg_sel = wr_addr[AXIS_SHIFT-1:0];
  assign cfg_write = wr_strobe && axis_hit && (reg_sel == REG_CONFIG);
  assign period_write = wr_strobe && axis_hit && (reg_sel == REG_PERIOD);
  assign move_write = wr_strobe && axis_hit && (reg_sel == REG_MOVE);

  // Magnitude of the signed count
  assign move_mag = wr_data[DATA_BITS-1] ? (~wr_data + 1'b1) : wr_data;
  assign phase_inc = PHASE_BITS'(1) << (USTEP_CODE_BITS'(PHASE_BITS - 1) - ustep_code);
  assign step_due = period_count >= period;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      enable <= 1'b0;
      ustep_code <= '0;
      period <= '1;  // Slowest rate until programmed
    end else begin
      if (cfg_write) begin
        enable <= wr_data[0];
        ustep_code <= wr_data[USTEP_CODE_BITS:1];
      end
      if (period_write) begin
        period <= wr_data[PERIOD_BITS-1:0];
      end
    end
  end

  // Move execution
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy <= 1'b0;
      dir_out <= 1'b0;
      step_out <= 1'b0;
      remaining <= '0;
      period_count <= '0;
      phase_index <= '0;
      position <= '0;
    end else begin
      step_out <= 1'b0;
      if (cfg_write && !wr_data[0]) begin
        // Disable aborts whatever is left
        busy <= 1'b0;
        remaining <= '0;
      end else if (move_write) begin
        busy <= enable && (move_mag != '0);
        dir_out <= wr_data[DATA_BITS-1];
        remaining <= move_mag;
        period_count <= PERIOD_BITS'(1);  // First pulse one period after busy
      end else if (busy) begin
        if (remaining == '0) begin
          busy <= 1'b0;  // Cycle after the last pulse
        end else if (step_due) begin
          step_out <= 1'b1;
          remaining <= remaining - 1'b1;
          period_count <= PERIOD_BITS'(1);
          if (dir_out) begin
            phase_index <= phase_index - phase_inc;
            position <= position - POSITION_BITS'(phase_inc);
          end else begin
            phase_index <= phase_index + phase_inc;
            position <= position + POSITION_BITS'(phase_inc);
          end
        end else begin
          period_count <= period_count + 1'b1;
        end
      end
    end
  end

  assign quadrant = phase_index[PHASE_BITS-1 -: 2];

  // Coil polarity per quadrant, all off when disabled
  always_ff @(posedge CLK) begin
    if (!resetn || !enable) begin
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
    end else begin
      phase_a1 <= (quadrant == 2'd0) || (quadrant == 2'd3);
      phase_a2 <= (quadrant == 2'd1) || (quadrant == 2'd2);
      phase_b1 <= !quadrant[1];
      phase_b2 <= quadrant[1];
    end
  end

  quad_encoder quad_encoder_inst (
    .CLK(CLK),
    .resetn(resetn),
    .enc_a(enc_a),
    .enc_b(enc_b),
    .count(enc_count),
    .fault_pulse(enc_fault_pulse)
  );

endmodule

//--- logic/status_collector.sv
`timescale 1ns/1ps

module status_collector (
  input  logic CLK,
  input  logic resetn,
  input  logic rd_strobe,
  input  logic [spi_pkg::ADDR_BITS-1:0] rd_addr,
  input  logic signed [motor_pkg::POSITION_BITS-1:0] position [motor_pkg::NUM_AXES],
  input  logic signed [motor_pkg::ENC_BITS-1:0] enc_count [motor_pkg::NUM_AXES],
  input  logic [motor_pkg::NUM_AXES-1:0] busy,
  input  logic [motor_pkg::NUM_AXES-1:0] enc_fault_pulse,
  output logic [spi_pkg::DATA_BITS-1:0] rd_data
);
  import motor_pkg::*;
  import spi_pkg::*;

  logic [ADDR_BITS-AXIS_SHIFT-1:0] rd_axis;
  logic [AXIS_SHIFT-1:0] rd_reg;
  logic [NUM_AXES-1:0] status_read;
  logic [NUM_AXES-1:0] fault_sticky;

  assign rd_axis = rd_addr[ADDR_BITS-1:AXIS_SHIFT];
  assign rd_reg = rd_addr[AXIS_SHIFT-1:0];

  always_comb begin
    for (int i = 0; i < NUM_AXES; i++) begin
      status_read[i] = rd_strobe && (rd_reg == REG_STATUS)
                       && (rd_axis == (ADDR_BITS - AXIS_SHIFT)'(i));
    end
  end

  // New fault beats a clearing read
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      fault_sticky <= '0;
    end else begin
      fault_sticky <= enc_fault_pulse | (fault_sticky & ~status_read);
    end
  end

  always_ff @(posedge CLK) begin
    if (rd_strobe) begin
      rd_data <= '0;  // Unmapped and write-only registers
      for (int i = 0; i < NUM_AXES; i++) begin
        if (rd_axis == (ADDR_BITS - AXIS_SHIFT)'(i)) begin
          case (rd_reg)
            REG_POSITION: rd_data <= position[i][DATA_BITS-1:0];
            REG_ENCODER: rd_data <= DATA_BITS'(enc_count[i]);
            REG_STATUS: rd_data <= {{(DATA_BITS - 2){1'b0}}, fault_sticky[i], busy[i]};
            default: rd_data <= '0;
          endcase
        end
      end
    end
  end

endmodule

//--- logic/stepper_core_top.sv
`timescale 1ns/1ps

module stepper_core_top (
  input  logic CLK,
  input  logic resetn_in,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  output logic cipo,
  input  logic [motor_pkg::NUM_AXES-1:0] enc_a,
  input  logic [motor_pkg::NUM_AXES-1:0] enc_b,
  output logic [motor_pkg::NUM_AXES-1:0] step_out,
  output logic [motor_pkg::NUM_AXES-1:0] dir_out,
  output logic [motor_pkg::NUM_AXES-1:0] busy,
  output logic [motor_pkg::NUM_AXES-1:0] phase_a1,
  output logic [motor_pkg::NUM_AXES-1:0] phase_a2,
  output logic [motor_pkg::NUM_AXES-1:0] phase_b1,
  output logic [motor_pkg::NUM_AXES-1:0] phase_b2
);
  import motor_pkg::*;
  import spi_pkg::*;

  logic resetn;  // Stretched internal reset

  // Register bus from the SPI port
  logic wr_strobe;
  logic [ADDR_BITS-1:0] wr_addr;
  logic [DATA_BITS-1:0] wr_data;
  logic rd_strobe;
  logic [ADDR_BITS-1:0] rd_addr;
  logic [DATA_BITS-1:0] rd_data;

  logic signed [POSITION_BITS-1:0] position [NUM_AXES];
  logic signed [ENC_BITS-1:0] enc_count [NUM_AXES];
  logic [NUM_AXES-1:0] enc_fault_pulse;

  reset_stretch reset_stretch_inst (
    .CLK(CLK),
    .resetn_in(resetn_in),
    .resetn(resetn)
  );

  spi_register_port spi_register_port_inst (
    .CLK(CLK),
    .resetn(resetn),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .cipo(cipo),
    .wr_strobe(wr_strobe),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_strobe(rd_strobe),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  // One channel per axis, writes broadcast to all
  for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
    axis_channel #(
      .AXIS_INDEX(i)
    ) axis_channel_inst (
      .CLK(CLK),
      .resetn(resetn),
      .wr_strobe(wr_strobe),
      .wr_addr(wr_addr),
      .wr_data(wr_data),
      .enc_a(enc_a[i]),
      .enc_b(enc_b[i]),
      .step_out(step_out[i]),
      .dir_out(dir_out[i]),
      .busy(busy[i]),
      .phase_a1(phase_a1[i]),
      .phase_a2(phase_a2[i]),
      .phase_b1(phase_b1[i]),
      .phase_b2(phase_b2[i]),
      .position(position[i]),
      .enc_count(enc_count[i]),
      .enc_fault_pulse(enc_fault_pulse[i])
    );
  end

  status_collector status_collector_inst (
    .CLK(CLK),
    .resetn(resetn),
    .rd_strobe(rd_strobe),
    .rd_addr(rd_addr),
    .position(position),
    .enc_count(enc_count),
    .busy(busy),
    .enc_fault_pulse(enc_fault_pulse),
    .rd_data(rd_data)
  );

endmodule

//--- testbench/stepper_core_properties.sv
`timescale 1ns/1ps

module stepper_core_properties (
  input logic CLK,
  input logic resetn,
  input logic cs,
  input logic cipo,
  input logic [motor_pkg::NUM_AXES-1:0] step_out,
  input logic [motor_pkg::NUM_AXES-1:0] busy,
  input logic [motor_pkg::NUM_AXES-1:0] phase_a1,
  input logic [motor_pkg::NUM_AXES-1:0] phase_a2,
  input logic [motor_pkg::NUM_AXES-1:0] phase_b1,
  input logic [motor_pkg::NUM_AXES-1:0] phase_b2
);

  int failures = 0;  // Polled by the testbench

  // Pulses are one cycle wide
  a_single_step: assert property (@(posedge CLK) disable iff (resetn !== 1'b1)
    (step_out & $past(step_out)) == '0)
    else begin
      failures++;
      $error("step_out high in two consecutive cycles");
    end

  a_step_busy: assert property (@(posedge CLK) disable iff (resetn !== 1'b1)
    (step_out & ~busy) == '0)
    else begin
      failures++;
      $error("step_out high while busy is low");
    end

  // No bridge drives both ends of a coil
  a_coil_a: assert property (@(posedge CLK) disable iff (resetn !== 1'b1)
    (phase_a1 & phase_a2) == '0)
    else begin
      failures++;
      $error("phase_a1 and phase_a2 both high");
    end

  a_coil_b: assert property (@(posedge CLK) disable iff (resetn !== 1'b1)
    (phase_b1 & phase_b2) == '0)
    else begin
      failures++;
      $error("phase_b1 and phase_b2 both high");
    end

  a_cipo_idle: assert property (@(posedge CLK) disable iff (resetn !== 1'b1)
    cs |-> !cipo)
    else begin
      failures++;
      $error("cipo driven while cs is high");
    end

endmodule

bind stepper_core_top stepper_core_properties properties_inst (
  .CLK(CLK),
  .resetn(resetn),
  .cs(cs),
  .cipo(cipo),
  .step_out(step_out),
  .busy(busy),
  .phase_a1(phase_a1),
  .phase_a2(phase_a2),
  .phase_b1(phase_b1),
  .phase_b2(phase_b2)
);

//--- testbench/stepper_core_tb.sv
`timescale 1ns/1ps

module stepper_core_tb;
  import motor_pkg::*;
  import spi_pkg::*;

  typedef enum int {KIND_CONFIG, KIND_MOVE, KIND_ENCODER, KIND_ILLEGAL} kind_t;

  typedef struct {
    string name;
    int axis;
    kind_t kind;
    int arg;       // Config is period<<16 | config word, encoder is fwd<<8 | rev
    int expected;
    int other;     // Neighbour axis position, low 16 bits
  } entry_t;

  logic CLK = 1'b0;
  logic resetn_in;
  logic sck;
  logic cs;
  logic copi;
  logic cipo;
  logic [NUM_AXES-1:0] enc_a;
  logic [NUM_AXES-1:0] enc_b;
  logic [NUM_AXES-1:0] step_out;
  logic [NUM_AXES-1:0] dir_out;
  logic [NUM_AXES-1:0] busy;
  logic [NUM_AXES-1:0] phase_a1;
  logic [NUM_AXES-1:0] phase_a2;
  logic [NUM_AXES-1:0] phase_b1;
  logic [NUM_AXES-1:0] phase_b2;

  entry_t table_q[$];
  int pulse_count [NUM_AXES];
  int enc_state [NUM_AXES];  // Gray position 0..3
  int model_pos [NUM_AXES];
  int model_enc [NUM_AXES];
  int period_of [NUM_AXES];
  int abort_code;
  int abort_steps;

  stepper_core_top stepper_core_top_inst (
    .CLK(CLK),
    .resetn_in(resetn_in),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .cipo(cipo),
    .enc_a(enc_a),
    .enc_b(enc_b),
    .step_out(step_out),
    .dir_out(dir_out),
    .busy(busy),
    .phase_a1(phase_a1),
    .phase_a2(phase_a2),
    .phase_b1(phase_b1),
    .phase_b2(phase_b2)
  );

  always #50 CLK = ~CLK;

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                                  name, expected, actual));
    end
  endtask

  // Step pulses counted away from the drive edge
  always @(negedge CLK) begin
    for (int i = 0; i < NUM_AXES; i++) begin
      if (step_out[i] === 1'b1) pulse_count[i] += 1;
    end
    if (stepper_core_top_inst.properties_inst.failures != 0) begin
      stop_with_failure("A bound assertion on the DUT failed");
    end
  end

  task automatic tick(input int n);
    repeat (n) begin
      @(posedge CLK);
      #10;
    end
  endtask

  // Mode 0, sck at CLK/8, cipo sampled just before each rising edge
  task automatic spi_frame(input logic [FRAME_BITS-1:0] tx, output logic [FRAME_BITS-1:0] rx);
    cs = 1'b0;
    tick(4);
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
      copi = tx[i];
      tick(4);
      rx[i] = cipo;
      sck = 1'b1;
      tick(4);
      sck = 1'b0;
    end
    tick(4);
    cs = 1'b1;
    copi = 1'b0;
    tick(8);
  endtask

  function automatic logic [ADDR_BITS-1:0] reg_addr(input int axis,
                                                    input logic [AXIS_SHIFT-1:0] offset);
    return ADDR_BITS'((axis << AXIS_SHIFT) | offset);
  endfunction

  task automatic write_reg(input int axis, input logic [AXIS_SHIFT-1:0] offset,
                           input logic [DATA_BITS-1:0] data);
    logic [FRAME_BITS-1:0] rx;
    spi_frame({1'b1, reg_addr(axis, offset), data}, rx);
  endtask

  task automatic expect_reg(input string name, input int axis,
                            input logic [AXIS_SHIFT-1:0] offset, input int expected);
    logic [FRAME_BITS-1:0] rx;
    spi_frame({1'b0, reg_addr(axis, offset), 16'h0000}, rx);
    spi_frame({1'b0, reg_addr(0, '1), 16'h0000}, rx);  // Unmapped read clocks the answer out
    check_value({name, " upper bits"}, 0, rx[FRAME_BITS-1:DATA_BITS]);
    check_value(name, expected & 16'hffff, rx[DATA_BITS-1:0]);
  endtask

  // Polarity order a1 a2 b1 b2
  function automatic logic [3:0] coil_pattern(input logic [1:0] quadrant);
    case (quadrant)
      2'd0: return 4'b1010;
      2'd1: return 4'b0110;
      2'd2: return 4'b0101;
      default: return 4'b1001;
    endcase
  endfunction

  function automatic logic [3:0] coils(input int axis);
    return {phase_a1[axis], phase_a2[axis], phase_b1[axis], phase_b2[axis]};
  endfunction

  task automatic wait_idle(input int axis, input int limit);
    int cycles;
    cycles = 0;
    while (busy[axis] && cycles < limit) begin
      tick(1);
      cycles++;
    end
    if (busy[axis]) begin
      stop_with_failure($sformatf("Axis %0d still busy after %0d cycles", axis, limit));
    end
  endtask

  // Delta 1 forward (b leads), 3 reverse, 2 flips both lines
  task automatic encoder_step(input int axis, input int delta);
    enc_state[axis] = (enc_state[axis] + delta) & 3;
    enc_a[axis] = enc_state[axis][1];
    enc_b[axis] = enc_state[axis][1] ^ enc_state[axis][0];
    tick(4);
  endtask

  task automatic add_entry(input string name, input int axis, input kind_t kind,
                           input int arg, input int expected, input int other);
    entry_t e;
    e = '{name, axis, kind, arg, expected, other};
    table_q.push_back(e);
  endtask

  task automatic build_table();
    int code;
    int inc;
    int count;
    int fwd;
    int rev;
    for (int round = 0; round < 3; round++) begin
      for (int a = 0; a < NUM_AXES; a++) begin
        code = $urandom % 8;
        inc = 1 << (PHASE_BITS - 1 - code);
        add_entry($sformatf("config axis %0d round %0d", a, round), a, KIND_CONFIG,
                  ((2 + $urandom % 6) << 16) | (code << 1) | 1,
                  coil_pattern(model_pos[a][7:6]), 0);
        for (int m = 0; m < 2; m++) begin
          count = 1 + $urandom % 20;
          if ($urandom % 2) count = -count;
          model_pos[a] += count * inc;
          add_entry($sformatf("move axis %0d round %0d n%0d", a, round, m), a, KIND_MOVE,
                    count, model_pos[a], model_pos[(a + 1) % NUM_AXES]);
        end
        fwd = $urandom % 12;
        rev = $urandom % 12;
        model_enc[a] += fwd - rev;
        add_entry($sformatf("encoder axis %0d round %0d", a, round), a, KIND_ENCODER,
                  (fwd << 8) | rev, model_enc[a], 0);
        add_entry($sformatf("illegal axis %0d round %0d", a, round), a, KIND_ILLEGAL,
                  0, model_enc[a], 0);
      end
    end
  endtask

  task automatic apply_entry(input entry_t e);
    int steps;
    steps = (e.arg < 0) ? -e.arg : e.arg;
    case (e.kind)
      KIND_CONFIG: begin
        period_of[e.axis] = e.arg >> 16;
        write_reg(e.axis, REG_PERIOD, 16'(e.arg >> 16));
        write_reg(e.axis, REG_CONFIG, e.arg[15:0]);
        check_value({e.name, " coils"}, e.expected, coils(e.axis));
      end
      KIND_MOVE: begin
        pulse_count[e.axis] = 0;
        write_reg(e.axis, REG_MOVE, e.arg[15:0]);
        wait_idle(e.axis, (steps + 2) * period_of[e.axis] + 20);
        tick(2);
        check_value({e.name, " pulses"}, steps, pulse_count[e.axis]);
        check_value({e.name, " dir"}, e.arg < 0, dir_out[e.axis]);
        check_value({e.name, " coils"}, coil_pattern(e.expected[7:6]), coils(e.axis));
        expect_reg({e.name, " position"}, e.axis, REG_POSITION, e.expected);
        expect_reg({e.name, " other axis"}, (e.axis + 1) % NUM_AXES, REG_POSITION, e.other);
      end
      KIND_ENCODER: begin
        repeat (e.arg >> 8) encoder_step(e.axis, 1);
        repeat (e.arg & 255) encoder_step(e.axis, 3);
        expect_reg({e.name, " count"}, e.axis, REG_ENCODER, e.expected);
      end
      default: begin
        encoder_step(e.axis, 2);
        expect_reg({e.name, " fault"}, e.axis, REG_STATUS, 2);
        expect_reg({e.name, " cleared"}, e.axis, REG_STATUS, 0);
        expect_reg({e.name, " count"}, e.axis, REG_ENCODER, e.expected);
      end
    endcase
  endtask

  initial begin
    void'($urandom(8912));
    resetn_in = 1'b0;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    enc_a = '0;
    enc_b = '0;
    for (int i = 0; i < NUM_AXES; i++) begin
      pulse_count[i] = 0;
      enc_state[i] = 0;
      model_pos[i] = 0;
      model_enc[i] = 0;
      period_of[i] = 2;
    end
    tick(2);
    resetn_in = 1'b1;
    tick(20);  // Stretcher holds internal reset 16 cycles

    check_value("reset busy", 0, busy);
    check_value("reset step", 0, step_out);
    check_value("reset coils", 0, {phase_a1, phase_a2, phase_b1, phase_b2});
    for (int a = 0; a < NUM_AXES; a++) begin
      expect_reg($sformatf("reset position axis %0d", a), a, REG_POSITION, 0);
      expect_reg($sformatf("reset status axis %0d", a), a, REG_STATUS, 0);
    end

    build_table();
    foreach (table_q[i]) apply_entry(table_q[i]);

    // Long move on axis 0, then disable it partway
    abort_code = $urandom % 8;
    write_reg(0, REG_PERIOD, 16'd200);
    write_reg(0, REG_CONFIG, 16'((abort_code << 1) | 1));
    pulse_count[0] = 0;
    write_reg(0, REG_MOVE, 16'd20);
    tick(500);
    check_value("abort move running", 1, busy[0]);
    write_reg(0, REG_CONFIG, 16'(abort_code << 1));
    abort_steps = pulse_count[0];
    check_value("abort busy", 0, busy[0]);
    check_value("abort coils", 0, coils(0));
    tick(600);  // Room for three more steps at this period
    check_value("abort no further steps", abort_steps, pulse_count[0]);
    model_pos[0] += pulse_count[0] * (1 << (PHASE_BITS - 1 - abort_code));
    expect_reg("abort position", 0, REG_POSITION, model_pos[0]);
    expect_reg("abort other axis", 1, REG_POSITION, model_pos[1]);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- compile.f
logic/motor_pkg.sv
logic/spi_pkg.sv
logic/reset_stretch.sv
logic/spi_register_port.sv
logic/quad_encoder.sv
logic/axis_channel.sv
logic/status_collector.sv
logic/stepper_core_top.sv
testbench/stepper_core_properties.sv
testbench/stepper_core_tb.sv

//--- Bender.yml
package:
  name: stepper_core

sources:
  - logic/motor_pkg.sv
  - logic/spi_pkg.sv
  - logic/reset_stretch.sv
  - logic/spi_register_port.sv
  - logic/quad_encoder.sv
  - logic/axis_channel.sv
  - logic/status_collector.sv
  - logic/stepper_core_top.sv
  - target: test
    files:
      - testbench/stepper_core_properties.sv
      - testbench/stepper_core_tb.sv
